// File: common/rv_isa_pkg.sv
// rv_isa_pkg: RV64I subset and machine CSR encodings, plus the decode control enums
package rv_isa_pkg;

  // major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // funct3, alu
  localparam logic [2:0] F3_ADD   = 3'b000;
  localparam logic [2:0] F3_SLL   = 3'b001;
  localparam logic [2:0] F3_XOR   = 3'b100;
  localparam logic [2:0] F3_OR    = 3'b110;
  localparam logic [2:0] F3_AND   = 3'b111;
  // funct3, branch / jump / memory / csr
  localparam logic [2:0] F3_BEQ   = 3'b000;
  localparam logic [2:0] F3_BNE   = 3'b001;
  localparam logic [2:0] F3_BLT   = 3'b100;
  localparam logic [2:0] F3_BGE   = 3'b101;
  localparam logic [2:0] F3_JALR  = 3'b000;
  localparam logic [2:0] F3_DWORD = 3'b011; // ld and sd
  localparam logic [2:0] F3_CSRRW = 3'b001;
  localparam logic [2:0] F3_CSRRS = 3'b010;

  localparam logic [6:0] F7_BASE  = 7'b0000000;
  localparam logic [6:0] F7_SUB   = 7'b0100000;

  // full words of the privileged instructions
  localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
  localparam logic [31:0] INST_EBREAK = 32'h0010_0073;
  localparam logic [31:0] INST_MRET   = 32'h3020_0073;

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  localparam logic [63:0] CAUSE_ECALL_M = 64'd11;

  localparam int GPR_A0 = 10; // ebreak reads its code from a0

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_JAL, BR_JALR
  } br_func_e;

  typedef enum logic [1:0] {
    MEM_NONE, MEM_LD, MEM_SD
  } mem_op_e;

  typedef enum logic [2:0] {
    CSR_OP_NONE, CSR_OP_RW, CSR_OP_RS, CSR_OP_ECALL, CSR_OP_MRET, CSR_OP_EBREAK
  } csr_op_e;

endpackage

// File: common/id_cfg_pkg.sv
// id_cfg_pkg: decode stage widths and machine CSR reset values
package id_cfg_pkg;

  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int CSR_ADDR_WD = 12;

  // uxl/sxl at 64 bit, mpp at machine
  localparam logic [63:0] MSTATUS_RESET = 64'h0000_000a_0000_1800;

  // trap vector, direct mode
  localparam logic [63:0] MTVEC_RESET   = 64'h0000_0000_8000_1000;

endpackage

// File: design/gpr_file.sv
// gpr_file: 32-entry general register file, two read ports and one write port
`timescale 1ns/1ps

module gpr_file #(
  parameter int XLEN,
  parameter int GPR_ADDR_WD
) (
  input  logic                   i_clk,
  input  logic [GPR_ADDR_WD-1:0] i_raddr1,
  input  logic [GPR_ADDR_WD-1:0] i_raddr2,
  output logic [XLEN-1:0]        o_rdata1,
  output logic [XLEN-1:0]        o_rdata2,
  input  logic                   i_wen,
  input  logic [GPR_ADDR_WD-1:0] i_waddr,
  input  logic [XLEN-1:0]        i_wdata
);

  logic [XLEN-1:0] regs [2**GPR_ADDR_WD];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 hardwired
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  // storage behind x0 never takes a write
  a_x0_write_dropped: assert property (@(posedge i_clk)
    i_wen && i_waddr == '0 |=> regs[0] === $past(regs[0]));

endmodule

// File: design/csr_file.sv
// csr_file: machine CSRs mstatus, mtvec, mepc and mcause with writeback and trap update
`timescale 1ns/1ps

module csr_file
  import id_cfg_pkg::*;
  import rv_isa_pkg::*;
#(
  parameter int XLEN,
  parameter int CSR_ADDR_WD
) (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic [CSR_ADDR_WD-1:0] i_raddr,
  output logic [XLEN-1:0]        o_rdata,
  input  logic                   i_wen,
  input  logic [CSR_ADDR_WD-1:0] i_waddr,
  input  logic [XLEN-1:0]        i_wdata,
  input  logic                   i_ecall,
  input  logic [XLEN-1:0]        i_epc,
  output logic [XLEN-1:0]        o_mtvec,
  output logic [XLEN-1:0]        o_mepc
);

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mstatus <= XLEN'(MSTATUS_RESET);
      mtvec   <= XLEN'(MTVEC_RESET);
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (i_wen) begin
        case (i_waddr)
          CSR_MSTATUS: mstatus <= i_wdata;
          CSR_MTVEC:   mtvec   <= i_wdata;
          CSR_MEPC:    mepc    <= i_wdata;
          CSR_MCAUSE:  mcause  <= i_wdata;
          default: ;
        endcase
      end
      // trap entry lands last, over any writeback
      if (i_ecall) begin
        mepc   <= i_epc;
        mcause <= XLEN'(CAUSE_ECALL_M);
      end
    end
  end

  always_comb begin
    case (i_raddr)
      CSR_MSTATUS: o_rdata = mstatus;
      CSR_MTVEC:   o_rdata = mtvec;
      CSR_MEPC:    o_rdata = mepc;
      CSR_MCAUSE:  o_rdata = mcause;
      default:     o_rdata = '0; // unimplemented csr
    endcase
  end

  assign o_mtvec = mtvec;
  assign o_mepc  = mepc;

endmodule

// File: design/br_unit.sv
// br_unit: branch compare and redirect target for branches, jumps, ecall and mret
`timescale 1ns/1ps

module br_unit
  import rv_isa_pkg::*;
#(
  parameter int XLEN
) (
  input  br_func_e        i_br_func,
  input  csr_op_e         i_csr_op,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  input  logic [XLEN-1:0] i_imm,
  input  logic [XLEN-1:0] i_mtvec,
  input  logic [XLEN-1:0] i_mepc,
  output logic            o_taken,
  output logic [XLEN-1:0] o_target
);

  logic [XLEN-1:0] jalr_sum;

  assign jalr_sum = i_rs1_data + i_imm;

  always_comb begin
    o_taken  = 1'b0;
    o_target = i_pc + i_imm; // pc-relative by default
    case (i_br_func)
      BR_BEQ: o_taken = (i_rs1_data == i_rs2_data);
      BR_BNE: o_taken = (i_rs1_data != i_rs2_data);
      BR_BLT: o_taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
      BR_BGE: o_taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      BR_JAL: o_taken = 1'b1;
      BR_JALR: begin
        o_taken  = 1'b1;
        o_target = {jalr_sum[XLEN-1:1], 1'b0};
      end
      default: o_taken = 1'b0;
    endcase

    if (i_csr_op == CSR_OP_ECALL) begin
      o_taken  = 1'b1;
      o_target = i_mtvec;
    end else if (i_csr_op == CSR_OP_MRET) begin
      o_taken  = 1'b1;
      o_target = i_mepc;
    end
  end

endmodule

// File: id_stage/id_decoder.sv
// id_decoder: splits an RV64 instruction word into register indices, immediate and controls
`timescale 1ns/1ps

module id_decoder
  import id_cfg_pkg::*;
  import rv_isa_pkg::*;
#(
  parameter int XLEN,
  parameter int GPR_ADDR_WD,
  parameter int CSR_ADDR_WD
) (
  input  logic [INST_WD-1:0]     i_inst,
  output logic [GPR_ADDR_WD-1:0] o_rs1,
  output logic [GPR_ADDR_WD-1:0] o_rs2,
  output logic [GPR_ADDR_WD-1:0] o_rd,
  output logic [XLEN-1:0]        o_imm,
  output logic [CSR_ADDR_WD-1:0] o_csr_addr,
  output alu_op_e                o_alu_op,
  output logic                   o_src1_pc,
  output logic                   o_src2_imm,
  output br_func_e               o_br_func,
  output mem_op_e                o_mem_op,
  output csr_op_e                o_csr_op,
  output logic                   o_gpr_wen,
  output logic                   o_invalid
);

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [GPR_ADDR_WD-1:0] f_rs1;
  logic [GPR_ADDR_WD-1:0] f_rs2;
  logic [GPR_ADDR_WD-1:0] f_rd;
  logic [XLEN-1:0]        imm_i;
  logic [XLEN-1:0]        imm_s;
  logic [XLEN-1:0]        imm_b;
  logic [XLEN-1:0]        imm_u;
  logic [XLEN-1:0]        imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign f_rs1  = i_inst[19:15];
  assign f_rs2  = i_inst[24:20];
  assign f_rd   = i_inst[11:7];

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    o_rs1      = '0;
    o_rs2      = '0;
    o_rd       = '0;
    o_imm      = '0;
    o_csr_addr = '0;
    o_alu_op   = ALU_ADD;
    o_src1_pc  = 1'b0;
    o_src2_imm = 1'b0;
    o_br_func  = BR_NONE;
    o_mem_op   = MEM_NONE;
    o_csr_op   = CSR_OP_NONE;
    o_gpr_wen  = 1'b0;
    o_invalid  = 1'b0;

    case (opcode)
      OP_LUI: begin
        o_rd       = f_rd;
        o_imm      = imm_u;
        o_alu_op   = ALU_PASS_B;
        o_src2_imm = 1'b1;
        o_gpr_wen  = 1'b1;
      end
      OP_AUIPC: begin
        o_rd       = f_rd;
        o_imm      = imm_u;
        o_src1_pc  = 1'b1;
        o_src2_imm = 1'b1;
        o_gpr_wen  = 1'b1;
      end
      OP_JAL: begin // link value pc+4 made in execute
        o_rd      = f_rd;
        o_imm     = imm_j;
        o_br_func = BR_JAL;
        o_src1_pc = 1'b1;
        o_gpr_wen = 1'b1;
      end
      OP_JALR: begin
        o_rs1     = f_rs1;
        o_rd      = f_rd;
        o_imm     = imm_i;
        o_br_func = BR_JALR;
        o_src1_pc = 1'b1;
        o_gpr_wen = 1'b1;
        o_invalid = (funct3 != F3_JALR);
      end
      OP_BRANCH: begin
        o_rs1    = f_rs1;
        o_rs2    = f_rs2;
        o_imm    = imm_b;
        o_alu_op = ALU_SUB;
        case (funct3)
          F3_BEQ:  o_br_func = BR_BEQ;
          F3_BNE:  o_br_func = BR_BNE;
          F3_BLT:  o_br_func = BR_BLT;
          F3_BGE:  o_br_func = BR_BGE;
          default: o_invalid = 1'b1;
        endcase
      end
      OP_LOAD: begin
        o_rs1      = f_rs1;
        o_rd       = f_rd;
        o_imm      = imm_i;
        o_src2_imm = 1'b1;
        o_mem_op   = MEM_LD;
        o_gpr_wen  = 1'b1;
        o_invalid  = (funct3 != F3_DWORD);
      end
      OP_STORE: begin
        o_rs1      = f_rs1;
        o_rs2      = f_rs2;
        o_imm      = imm_s;
        o_src2_imm = 1'b1;
        o_mem_op   = MEM_SD;
        o_invalid  = (funct3 != F3_DWORD);
      end
      OP_IMM: begin
        o_rs1      = f_rs1;
        o_rd       = f_rd;
        o_imm      = imm_i;
        o_src2_imm = 1'b1;
        o_gpr_wen  = 1'b1;
        if (funct3 == F3_ADD) begin
          o_alu_op = ALU_ADD;
        end else if (funct3 == F3_SLL && i_inst[31:26] == 6'b0) begin // 6-bit shamt
          o_alu_op = ALU_SLL;
        end else begin
          o_invalid = 1'b1;
        end
      end
      OP_REG: begin
        o_rs1     = f_rs1;
        o_rs2     = f_rs2;
        o_rd      = f_rd;
        o_gpr_wen = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, F3_ADD}: o_alu_op = ALU_ADD;
          {F7_SUB,  F3_ADD}: o_alu_op = ALU_SUB;
          {F7_BASE, F3_AND}: o_alu_op = ALU_AND;
          {F7_BASE, F3_OR}:  o_alu_op = ALU_OR;
          {F7_BASE, F3_XOR}: o_alu_op = ALU_XOR;
          default:           o_invalid = 1'b1;
        endcase
      end
      OP_SYSTEM: begin
        if (funct3 == F3_CSRRW || funct3 == F3_CSRRS) begin
          o_rs1      = f_rs1;
          o_rd       = f_rd;
          o_csr_addr = i_inst[31:20];
          o_gpr_wen  = 1'b1;
          if (funct3 == F3_CSRRW) begin
            o_csr_op = CSR_OP_RW;
            o_alu_op = ALU_PASS_B;
          end else begin
            o_csr_op = CSR_OP_RS;
            o_alu_op = ALU_OR;
          end
        end else if (i_inst == INST_ECALL) begin
          o_csr_op   = CSR_OP_ECALL;
          o_csr_addr = CSR_MTVEC; // trap target
        end else if (i_inst == INST_MRET) begin
          o_csr_op   = CSR_OP_MRET;
          o_csr_addr = CSR_MEPC;
        end else if (i_inst == INST_EBREAK) begin
          o_csr_op = CSR_OP_EBREAK;
        end else begin
          o_invalid = 1'b1;
        end
      end
      default: o_invalid = 1'b1;
    endcase

    // illegal words write nothing and never stall
    if (o_invalid) begin
      o_rs1      = '0;
      o_rs2      = '0;
      o_rd       = '0;
      o_csr_addr = '0;
      o_br_func  = BR_NONE;
      o_mem_op   = MEM_NONE;
      o_csr_op   = CSR_OP_NONE;
      o_gpr_wen  = 1'b0;
    end
  end

endmodule

// File: id_stage/id_stage.sv
// id_stage: instruction decode with operand read, hazard stall and branch redirect
`timescale 1ns/1ps

module id_stage
  import id_cfg_pkg::*;
  import rv_isa_pkg::*;
#(
  parameter int XLEN        = id_cfg_pkg::XLEN,
  parameter int GPR_ADDR_WD = id_cfg_pkg::GPR_ADDR_WD,
  parameter int CSR_ADDR_WD = id_cfg_pkg::CSR_ADDR_WD
) (
  input  logic                   i_clk,
  input  logic                   i_rst,
  // fetch side
  input  logic                   i_fs_valid,
  input  logic [XLEN-1:0]        i_fs_pc,
  input  logic [INST_WD-1:0]     i_fs_inst,
  output logic                   o_ds_allowin,
  input  logic                   i_es_allowin,
  // destinations still in flight
  input  logic [GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [GPR_ADDR_WD-1:0] i_wb_rd,
  input  logic [CSR_ADDR_WD-1:0] i_es_csr,
  input  logic [CSR_ADDR_WD-1:0] i_ms_csr,
  input  logic [CSR_ADDR_WD-1:0] i_wb_csr,
  // writeback into the register files
  input  logic                   i_wb_gpr_wen,
  input  logic [GPR_ADDR_WD-1:0] i_wb_gpr_addr,
  input  logic [XLEN-1:0]        i_wb_gpr_data,
  input  logic                   i_wb_csr_wen,
  input  logic [CSR_ADDR_WD-1:0] i_wb_csr_addr,
  input  logic [XLEN-1:0]        i_wb_csr_data,
  // to execute
  output logic                   o_es_valid,
  output logic [XLEN-1:0]        o_es_pc,
  output logic [XLEN-1:0]        o_es_rs1_data,
  output logic [XLEN-1:0]        o_es_rs2_data,
  output logic [XLEN-1:0]        o_es_csr_data,
  output logic [XLEN-1:0]        o_es_imm,
  output logic [GPR_ADDR_WD-1:0] o_es_rd,
  output logic [CSR_ADDR_WD-1:0] o_es_csr_addr,
  output alu_op_e                o_es_alu_op,
  output logic                   o_es_src1_pc,
  output logic                   o_es_src2_imm,
  output mem_op_e                o_es_mem_op,
  output csr_op_e                o_es_csr_op,
  output logic                   o_es_gpr_wen,
  output logic                   o_es_invalid,
  // redirect to fetch
  output logic                   o_br_taken,
  output logic [XLEN-1:0]        o_br_target
);

  logic                   ds_valid;
  logic [XLEN-1:0]        ds_pc;
  logic [INST_WD-1:0]     ds_inst;
  logic [GPR_ADDR_WD-1:0] rs1;
  logic [GPR_ADDR_WD-1:0] rs2;
  logic [GPR_ADDR_WD-1:0] src1;
  logic [XLEN-1:0]        mtvec;
  logic [XLEN-1:0]        mepc;
  br_func_e               br_func;
  logic                   br_taken;
  logic                   gpr_hazard;
  logic                   csr_hazard;
  logic                   ds_ready;
  logic                   ecall_leave;

  function automatic logic gpr_hit(input logic [GPR_ADDR_WD-1:0] dst,
                                   input logic [GPR_ADDR_WD-1:0] s1,
                                   input logic [GPR_ADDR_WD-1:0] s2);
    return (dst != '0) && (dst == s1 || dst == s2);
  endfunction

  function automatic logic csr_hit(input logic [CSR_ADDR_WD-1:0] dst,
                                   input logic [CSR_ADDR_WD-1:0] src);
    return (dst != '0) && (dst == src);
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      ds_pc   <= i_fs_pc;
      ds_inst <= i_fs_inst;
    end
  end

  // ebreak reads a0 through port 1
  assign src1 = (o_es_csr_op == CSR_OP_EBREAK) ? GPR_ADDR_WD'(GPR_A0) : rs1;

  assign gpr_hazard = gpr_hit(i_es_rd, src1, rs2) || gpr_hit(i_ms_rd, src1, rs2)
                   || gpr_hit(i_wb_rd, src1, rs2);
  assign csr_hazard = csr_hit(i_es_csr, o_es_csr_addr) || csr_hit(i_ms_csr, o_es_csr_addr)
                   || csr_hit(i_wb_csr, o_es_csr_addr);
  assign ds_ready   = !(gpr_hazard || csr_hazard);

  assign o_ds_allowin = !ds_valid || (ds_ready && i_es_allowin);
  assign o_es_valid   = ds_valid && ds_ready;
  assign o_es_pc      = ds_pc;
  assign ecall_leave  = o_es_valid && i_es_allowin && (o_es_csr_op == CSR_OP_ECALL);
  assign o_br_taken   = o_es_valid && br_taken; // no redirect while stalled

  id_decoder #(
    .XLEN        (XLEN),
    .GPR_ADDR_WD (GPR_ADDR_WD),
    .CSR_ADDR_WD (CSR_ADDR_WD)
  ) u_decoder (
    .i_inst      (ds_inst),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (o_es_rd),
    .o_imm       (o_es_imm),
    .o_csr_addr  (o_es_csr_addr),
    .o_alu_op    (o_es_alu_op),
    .o_src1_pc   (o_es_src1_pc),
    .o_src2_imm  (o_es_src2_imm),
    .o_br_func   (br_func),
    .o_mem_op    (o_es_mem_op),
    .o_csr_op    (o_es_csr_op),
    .o_gpr_wen   (o_es_gpr_wen),
    .o_invalid   (o_es_invalid)
  );

  gpr_file #(
    .XLEN        (XLEN),
    .GPR_ADDR_WD (GPR_ADDR_WD)
  ) u_gpr (
    .i_clk       (i_clk),
    .i_raddr1    (src1),
    .i_raddr2    (rs2),
    .o_rdata1    (o_es_rs1_data),
    .o_rdata2    (o_es_rs2_data),
    .i_wen       (i_wb_gpr_wen),
    .i_waddr     (i_wb_gpr_addr),
    .i_wdata     (i_wb_gpr_data)
  );

  csr_file #(
    .XLEN        (XLEN),
    .CSR_ADDR_WD (CSR_ADDR_WD)
  ) u_csr (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_raddr     (o_es_csr_addr),
    .o_rdata     (o_es_csr_data),
    .i_wen       (i_wb_csr_wen),
    .i_waddr     (i_wb_csr_addr),
    .i_wdata     (i_wb_csr_data),
    .i_ecall     (ecall_leave),
    .i_epc       (ds_pc),
    .o_mtvec     (mtvec),
    .o_mepc      (mepc)
  );

  br_unit #(
    .XLEN        (XLEN)
  ) u_br (
    .i_br_func   (br_func),
    .i_csr_op    (o_es_csr_op),
    .i_pc        (ds_pc),
    .i_rs1_data  (o_es_rs1_data),
    .i_rs2_data  (o_es_rs2_data),
    .i_imm       (o_es_imm),
    .i_mtvec     (mtvec),
    .i_mepc      (mepc),
    .o_taken     (br_taken),
    .o_target    (o_br_target)
  );

  // an instruction that left is sent again only after a new accept
  a_valid_source: assert property (@(posedge i_clk) disable iff (i_rst)
    o_es_valid && i_es_allowin |=> !o_es_valid || $past(i_fs_valid));

  // back-pressure keeps the instruction in place
  a_hold_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    o_es_valid && !i_es_allowin |=> $stable(o_es_pc) && $stable(o_es_imm)
      && $stable(o_es_rd) && $stable(o_es_alu_op) && $stable(o_es_csr_op));

endmodule

// File: tb/tb_id_stage.sv
// tb_id_stage: file-driven testbench for the decode stage, playing fetch, execute and writeback
`timescale 1ns/1ps

module tb_id_stage
  import id_cfg_pkg::*;
  import rv_isa_pkg::*;
();

  localparam int RESET_CYCLES    = 8;
  localparam int CYCLES_PER_LINE = 20;

  logic                   i_clk;
  logic                   i_rst;
  logic                   i_fs_valid;
  logic [XLEN-1:0]        i_fs_pc;
  logic [INST_WD-1:0]     i_fs_inst;
  logic                   i_es_allowin;
  logic [GPR_ADDR_WD-1:0] i_es_rd;
  logic [GPR_ADDR_WD-1:0] i_ms_rd;
  logic [GPR_ADDR_WD-1:0] i_wb_rd;
  logic [CSR_ADDR_WD-1:0] i_es_csr;
  logic [CSR_ADDR_WD-1:0] i_ms_csr;
  logic [CSR_ADDR_WD-1:0] i_wb_csr;
  logic                   i_wb_gpr_wen;
  logic [GPR_ADDR_WD-1:0] i_wb_gpr_addr;
  logic [XLEN-1:0]        i_wb_gpr_data;
  logic                   i_wb_csr_wen;
  logic [CSR_ADDR_WD-1:0] i_wb_csr_addr;
  logic [XLEN-1:0]        i_wb_csr_data;
  logic                   o_ds_allowin;
  logic                   o_es_valid;
  logic [XLEN-1:0]        o_es_pc;
  logic [XLEN-1:0]        o_es_rs1_data;
  logic [XLEN-1:0]        o_es_rs2_data;
  logic [XLEN-1:0]        o_es_csr_data;
  logic [XLEN-1:0]        o_es_imm;
  logic [GPR_ADDR_WD-1:0] o_es_rd;
  logic [CSR_ADDR_WD-1:0] o_es_csr_addr;
  alu_op_e                o_es_alu_op;
  logic                   o_es_src1_pc;
  logic                   o_es_src2_imm;
  mem_op_e                o_es_mem_op;
  csr_op_e                o_es_csr_op;
  logic                   o_es_gpr_wen;
  logic                   o_es_invalid;
  logic                   o_br_taken;
  logic [XLEN-1:0]        o_br_target;

  int   value_errors;
  int   other_errors;
  int   n_lines;
  logic lines_known;

  // what the instruction in the stage should show
  logic                   exp_valid;
  logic [XLEN-1:0]        exp_pc;
  logic [GPR_ADDR_WD-1:0] exp_rd;
  logic [XLEN-1:0]        exp_imm;
  alu_op_e                exp_alu;
  mem_op_e                exp_mem;
  csr_op_e                exp_csr_op;
  logic                   exp_wen;
  logic                   exp_inv;
  logic [XLEN-1:0]        exp_rs1;
  logic [XLEN-1:0]        exp_rs2;
  logic [XLEN-1:0]        exp_csr;
  logic                   exp_taken;
  logic [XLEN-1:0]        exp_target;
  logic [CSR_ADDR_WD-1:0] exp_csr_addr;
  logic                   exp_src1_pc;
  logic                   exp_src2_imm;

  id_stage #(
    .XLEN        (XLEN),
    .GPR_ADDR_WD (GPR_ADDR_WD),
    .CSR_ADDR_WD (CSR_ADDR_WD)
  ) i_id_stage (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  task automatic next_cycle();
    @(posedge i_clk);
    #1;
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_alu_op(input string name, input alu_op_e got, input alu_op_e exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_mem_op(input string name, input mem_op_e got, input mem_op_e exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_csr_op(input string name, input csr_op_e got, input csr_op_e exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  // operand selects and the csr index follow from the opcode
  task automatic derive_controls(input logic [INST_WD-1:0] inst);
    exp_src1_pc  = 1'b0;
    exp_src2_imm = 1'b0;
    exp_csr_addr = '0;
    case (inst[6:0])
      OP_LUI, OP_IMM, OP_LOAD, OP_STORE: exp_src2_imm = 1'b1;
      OP_AUIPC: begin
        exp_src1_pc  = 1'b1;
        exp_src2_imm = 1'b1;
      end
      OP_JAL, OP_JALR: exp_src1_pc = 1'b1; // link from pc
      OP_SYSTEM: begin
        if (inst[14:12] == F3_CSRRW || inst[14:12] == F3_CSRRS) begin
          exp_csr_addr = inst[31:20];
        end else if (inst == INST_ECALL) begin
          exp_csr_addr = CSR_MTVEC;
        end else if (inst == INST_MRET) begin
          exp_csr_addr = CSR_MEPC;
        end
      end
      default: ;
    endcase
  endtask

  task automatic check_fields(input logic valid_now, input logic allowin_now);
    check_flag("o_es_valid", o_es_valid, valid_now);
    check_flag("o_ds_allowin", o_ds_allowin, allowin_now);
    check_data("o_es_pc", o_es_pc, exp_pc);
    check_data("o_es_rd", XLEN'(o_es_rd), XLEN'(exp_rd));
    check_data("o_es_imm", o_es_imm, exp_imm);
    check_alu_op("o_es_alu_op", o_es_alu_op, exp_alu);
    check_mem_op("o_es_mem_op", o_es_mem_op, exp_mem);
    check_csr_op("o_es_csr_op", o_es_csr_op, exp_csr_op);
    check_flag("o_es_gpr_wen", o_es_gpr_wen, exp_wen);
    check_flag("o_es_invalid", o_es_invalid, exp_inv);
    check_data("o_es_csr_addr", XLEN'(o_es_csr_addr), XLEN'(exp_csr_addr));
    if (!exp_inv) begin
      check_flag("o_es_src1_pc", o_es_src1_pc, exp_src1_pc);
      check_flag("o_es_src2_imm", o_es_src2_imm, exp_src2_imm);
    end
    check_data("o_es_rs1_data", o_es_rs1_data, exp_rs1);
    check_data("o_es_rs2_data", o_es_rs2_data, exp_rs2);
    check_data("o_es_csr_data", o_es_csr_data, exp_csr);
    check_flag("o_br_taken", o_br_taken, valid_now && exp_taken); // no redirect while stalled
    if (valid_now && exp_taken) begin
      check_data("o_br_target", o_br_target, exp_target);
    end
  endtask

  task automatic set_hazard(input logic [1:0] sel, input logic [GPR_ADDR_WD-1:0] rd,
                            input logic [CSR_ADDR_WD-1:0] csr);
    i_es_rd  = '0;
    i_ms_rd  = '0;
    i_wb_rd  = '0;
    i_es_csr = '0;
    i_ms_csr = '0;
    i_wb_csr = '0;
    case (sel)
      2'd0: begin
        i_es_rd  = rd;
        i_es_csr = csr;
      end
      2'd1: begin
        i_ms_rd  = rd;
        i_ms_csr = csr;
      end
      default: begin
        i_wb_rd  = rd;
        i_wb_csr = csr;
      end
    endcase
  endtask

  task automatic write_step(input string line);
    logic [3:0]      kind;
    logic [11:0]     addr;
    logic [XLEN-1:0] data;
    int              n;
    n = $sscanf(line, "%h %h %h", kind, addr, data);
    if (n != 3) begin
      $display("malformed register write line in stimulus file: %s", line);
      other_errors++;
    end else begin
      next_cycle();
      if (kind == 4'd1) begin
        i_wb_gpr_wen  = 1'b1;
        i_wb_gpr_addr = addr[GPR_ADDR_WD-1:0];
        i_wb_gpr_data = data;
      end else begin
        i_wb_csr_wen  = 1'b1;
        i_wb_csr_addr = addr[CSR_ADDR_WD-1:0];
        i_wb_csr_data = data;
      end
      next_cycle();
      i_wb_gpr_wen = 1'b0;
      i_wb_csr_wen = 1'b0;
    end
  endtask

  task automatic issue_step(input string line);
    logic [3:0]             kind;
    logic [INST_WD-1:0]     inst;
    logic [1:0]             hz_sel;
    logic [GPR_ADDR_WD-1:0] hz_rd;
    logic [CSR_ADDR_WD-1:0] hz_csr;
    logic                   allowin;
    logic [2:0]             alu;
    logic [1:0]             mem;
    logic [2:0]             csr_op;
    int                     n;
    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                kind, exp_pc, inst, hz_sel, hz_rd, hz_csr, allowin, exp_valid, exp_rd,
                exp_imm, alu, mem, csr_op, exp_wen, exp_inv, exp_rs1, exp_rs2, exp_csr,
                exp_taken, exp_target);
    if (n != 20) begin
      $display("malformed issue line in stimulus file: %s", line);
      other_errors++;
    end else begin
      exp_alu    = alu_op_e'(alu);
      exp_mem    = mem_op_e'(mem);
      exp_csr_op = csr_op_e'(csr_op);
      derive_controls(inst);
      next_cycle();
      i_fs_valid   = 1'b1;
      i_fs_pc      = exp_pc;
      i_fs_inst    = inst;
      i_es_allowin = allowin;
      set_hazard(hz_sel, hz_rd, hz_csr);
      #1;
      while (!o_ds_allowin) begin
        @(posedge i_clk);
        #2;
      end
      next_cycle(); // accepting edge
      i_fs_valid = 1'b0;
      #2;
      check_fields(exp_valid, exp_valid && allowin);
    end
  endtask

  // fetch keeps offering a word while the stage is full and then the hold is lifted
  task automatic release_step();
    repeat (2) begin
      next_cycle();
      i_fs_valid = 1'b1;
      i_fs_pc    = 64'h0000_0000_dead_0000;
      i_fs_inst  = 32'h0000_0013;
      #2;
      check_fields(exp_valid, 1'b0);
    end
    next_cycle();
    i_fs_valid   = 1'b0;
    i_es_allowin = 1'b1;
    set_hazard(2'd0, '0, '0);
    #2;
    check_fields(1'b1, 1'b1);
  endtask

  task automatic run_step(input string line);
    logic [3:0] kind;
    if ($sscanf(line, "%h", kind) != 1) begin
      $display("stimulus line has no step kind: %s", line);
      other_errors++;
    end else begin
      case (kind)
        4'd1, 4'd2: write_step(line);
        4'd3:       issue_step(line);
        4'd4:       release_step();
        default: begin
          $display("unknown step kind %0d in stimulus file", kind);
          other_errors++;
        end
      endcase
    end
  endtask

  task automatic report_counts();
    $display("errors: value %0d, other %0d", value_errors, other_errors);
  endtask

  initial begin
    int    fd;
    string line;
    value_errors  = 0;
    other_errors  = 0;
    n_lines       = 0;
    lines_known   = 1'b0;
    i_rst         = 1'b1;
    i_fs_valid    = 1'b0;
    i_fs_pc       = '0;
    i_fs_inst     = '0;
    i_es_allowin  = 1'b1;
    i_wb_gpr_wen  = 1'b0;
    i_wb_gpr_addr = '0;
    i_wb_gpr_data = '0;
    i_wb_csr_wen  = 1'b0;
    i_wb_csr_addr = '0;
    i_wb_csr_data = '0;
    set_hazard(2'd0, '0, '0);

    fd = $fopen("tb/id_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open stimulus file tb/id_input.txt");
      other_errors++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        n_lines++;
      end
      $fclose(fd);
      lines_known = 1'b1;
      fd = $fopen("tb/id_input.txt", "r");
    end

    repeat (RESET_CYCLES) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    #2;
    check_flag("o_es_valid", o_es_valid, 1'b0);
    check_flag("o_ds_allowin", o_ds_allowin, 1'b1);
    check_flag("o_br_taken", o_br_taken, 1'b0);

    if (fd != 0) begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          run_step(line);
        end
      end
      $fclose(fd);
    end

    repeat (2) next_cycle();
    report_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (lines_known);
    repeat (RESET_CYCLES + CYCLES_PER_LINE * n_lines) @(posedge i_clk);
    other_errors++;
    $display("timeout: stimulus not finished after %0d cycles",
             RESET_CYCLES + CYCLES_PER_LINE * n_lines);
    report_counts();
    $display("test failed");
    $finish;
  end

endmodule

// File: tb/id_input.txt
# kind 1 gpr write, kind 2 csr write: addr data. kind 4: hold two cycles, then release
# kind 3 issue: pc inst hz_sel hz_rd hz_csr allowin, valid rd imm alu mem csr wen inv rs1 rs2 csr taken target
1 01 1000
1 02 fffffffffffffff0
1 03 1000
1 0a aa
1 00 dead
3 80000000 01008293 0 0 0 1 1 05 10 0 0 0 1 0 1000 0 0 0 0
3 80000004 00208333 0 0 0 1 1 06 0 0 0 0 1 0 1000 fffffffffffffff0 0 0 0
3 80000008 402083b3 0 0 0 1 1 07 0 1 0 0 1 0 1000 fffffffffffffff0 0 0 0
3 8000000c 0030f433 0 0 0 1 1 08 0 2 0 0 1 0 1000 1000 0 0 0
3 80000010 003164b3 0 0 0 1 1 09 0 3 0 0 1 0 fffffffffffffff0 1000 0 0 0
3 80000014 0020c5b3 0 0 0 1 1 0b 0 4 0 0 1 0 1000 fffffffffffffff0 0 0 0
3 80000018 00309613 0 0 0 1 1 0c 3 5 0 0 1 0 1000 0 0 0 0
3 8000001c 123456b7 0 0 0 1 1 0d 12345000 6 0 0 1 0 0 0 0 0 0
3 80000020 800006b7 0 0 0 1 1 0d ffffffff80000000 6 0 0 1 0 0 0 0 0 0
3 80000024 00001717 0 0 0 1 1 0e 1000 0 0 0 1 0 0 0 0 0 0
3 80000028 0080b783 0 0 0 1 1 0f 8 0 1 0 1 0 1000 0 0 0 0
3 8000002c fe20bc23 0 0 0 1 1 00 fffffffffffffff8 0 2 0 0 0 1000 fffffffffffffff0 0 0 0
3 80000030 023100b3 0 0 0 1 1 00 0 0 0 0 0 1 0 0 0 0 0
3 80000034 00000000 0 0 0 1 1 00 0 0 0 0 0 1 0 0 0 0 0
3 80000038 001008b3 0 0 0 1 1 11 0 0 0 0 1 0 0 1000 0 0 0
3 80000100 00308863 0 0 0 1 1 00 10 1 0 0 0 0 1000 1000 0 1 80000110
3 80000104 00309863 0 0 0 1 1 00 10 1 0 0 0 0 1000 1000 0 0 0
3 80000200 fe114ce3 0 0 0 1 1 00 fffffffffffffff8 1 0 0 0 0 fffffffffffffff0 1000 0 1 800001f8
3 80000204 fe115ce3 0 0 0 1 1 00 fffffffffffffff8 1 0 0 0 0 fffffffffffffff0 1000 0 0 0
3 80000300 0020d863 0 0 0 1 1 00 10 1 0 0 0 0 1000 fffffffffffffff0 0 1 80000310
3 80000400 001000ef 0 0 0 1 1 01 800 0 0 0 1 0 0 0 0 1 80000c00
3 80000404 00508067 0 0 0 1 1 00 5 0 0 0 1 0 1000 0 0 1 1004
3 80000500 00208333 0 02 0 1 0 06 0 0 0 0 1 0 1000 fffffffffffffff0 0 0 0
4
3 80000504 0030f433 1 01 0 1 0 08 0 2 0 0 1 0 1000 1000 0 0 0
4
3 80000508 00208333 2 09 0 1 1 06 0 0 0 0 1 0 1000 fffffffffffffff0 0 0 0
3 8000050c 00100073 0 0a 0 1 0 00 0 0 0 5 0 0 aa 0 0 0 0
4
3 80000510 00308863 2 03 0 1 0 00 10 1 0 0 0 0 1000 1000 0 1 80000520
4
3 80000600 01008293 0 0 0 0 1 05 10 0 0 0 1 0 1000 0 0 0 0
4
3 80000700 30502a73 0 0 0 1 1 14 0 3 0 2 1 0 0 0 80001000 0 0
3 80000704 30002a73 0 0 0 1 1 14 0 3 0 2 1 0 0 0 a00001800 0 0
3 80000708 34009af3 0 0 0 1 1 15 0 6 0 1 1 0 1000 0 0 0 0
2 305 80002000
3 80000800 00000073 0 0 0 1 1 00 0 0 0 3 0 0 0 0 80002000 1 80002000
3 80000804 34102a73 2 0 341 1 0 14 0 3 0 2 1 0 0 0 80000800 0 0
4
3 80000808 34202a73 0 0 0 1 1 14 0 3 0 2 1 0 0 0 b 0 0
3 8000080c 30200073 0 0 0 1 1 00 0 0 0 4 0 0 0 0 80000800 1 80000800
3 80000810 00000073 0 0 305 1 0 00 0 0 0 3 0 0 0 0 80002000 1 80002000
4
3 80000814 30200073 0 0 0 1 1 00 0 0 0 4 0 0 0 0 80000810 1 80000810

// File: list.f
common/rv_isa_pkg.sv
common/id_cfg_pkg.sv
design/gpr_file.sv
design/csr_file.sv
design/br_unit.sv
id_stage/id_decoder.sv
id_stage/id_stage.sv
tb/tb_id_stage.sv

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f list.f --top-module tb_id_stage \
  -Mdir obj_dir -o vsim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/vsim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" sim.log; then
  exit 1
fi
exit 0
